// File: build.f
+incdir+.
ipod_pkg.sv
key_conditioner.sv
sample_rate_ctrl.sv
sample_sequencer.sv
level_meter.sv
hex_display.sv
simple_ipod.sv
tb_simple_ipod.sv

// File: Bender.yml
package:
  name: simple_ipod

export_include_dirs:
  - .

sources:
  - files:
      - ipod_pkg.sv
      - key_conditioner.sv
      - sample_rate_ctrl.sv
      - sample_sequencer.sv
      - level_meter.sv
      - hex_display.sv
      - simple_ipod.sv
  - target: simulation
    files:
      - tb_simple_ipod.sv

// File: tb_simple_ipod.sv
`timescale 1ns/1ps
`include "simple_ipod_consts.svh"

module tb_simple_ipod import ipod_pkg::*;;

  localparam int REPEAT_INTERVAL = 64;
  localparam int SONG_LAST       = 7;
  localparam int NUM_ROWS        = 5;
  localparam int KEY_NONE        = 0;
  localparam int KEY_UP          = 1;
  localparam int KEY_DOWN        = 2;
  localparam int KEY_RST         = 3;

  logic        CLK_50M = 1'b0;
  logic        reset;
  logic [2:0]  key;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  logic        audio_valid;
  sample_t     audio_sample;
  logic        audio_ready;
  logic [7:0]  led;
  seg7_t       hex0;
  seg7_t       hex1;
  seg7_t       hex2;
  seg7_t       hex3;

  // Stimulus table, one entry per row
  string     row_name    [NUM_ROWS];
  int        row_key     [NUM_ROWS];
  int        row_events  [NUM_ROWS];
  bit        row_random  [NUM_ROWS];
  int        row_samples [NUM_ROWS];
  clk_div_t  row_div     [NUM_ROWS];
  int        row_count = 0;

  logic [15:0] lfsr_state = 16'd64125;
  bit          ready_random = 1'b0;
  string       cur_name = "reset";
  int          taken = 0;          // Accepted samples so far
  int          mag_sum = 0;
  int          led_wait = 0;
  logic [7:0]  exp_led;
  int          rdv_cnt = 0;
  flash_addr_t rd_addr;
  int          limit_cycles = 0;

  simple_ipod #(
    .REPEAT_CYCLES (REPEAT_INTERVAL),
    .LAST_WORD     (flash_addr_t'(SONG_LAST))
  ) simple_ipod_inst (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .key                 (key),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_valid         (audio_valid),
    .audio_sample        (audio_sample),
    .audio_ready         (audio_ready),
    .led                 (led),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3)
  );

  always #10 CLK_50M = ~CLK_50M;   // 50 MHz

  // ==================================================
  // Reference models
  // ==================================================
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
  endfunction

  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
    return val;
  endfunction

  // Byte n of word a is a*4+n, scrambled with A5
  function automatic flash_word_t flash_word(input flash_addr_t addr);
    flash_word_t w;
    for (int n = 0; n < 4; n++)
      w[8*n +: 8] = 8'(addr * 4 + n) ^ 8'hA5;
    return w;
  endfunction

  function automatic sample_t expected_sample(input int idx);
    int word_addr;
    int byte_pos;
    word_addr = (idx / 4) % (SONG_LAST + 1);
    byte_pos  = idx % 4;
    return sample_t'(8'(word_addr * 4 + byte_pos) ^ 8'hA5);
  endfunction

  function automatic int magnitude(input sample_t s);
    return (s < 0) ? -int'(s) : int'(s);
  endfunction

  function automatic logic [7:0] thermometer(input int level);
    logic [7:0] t;
    for (int i = 0; i < 8; i++)
      t[i] = (i < level);
    return t;
  endfunction

  // Lit segments, common cathode style, bit 0 is segment a
  function automatic seg7_t lit_segments(input logic [3:0] nib);
    seg7_t lit;
    case (nib)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return lit;
  endfunction

  // ==================================================
  // Checks
  // ==================================================
  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act)
    begin
      $display("Error: test %s sample %0d expected %h actual %h", name, taken, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_div(input string name, input clk_div_t exp_div,
                           input seg7_t d0, input seg7_t d1, input seg7_t d2, input seg7_t d3);
    logic [27:0] exp_segs;
    logic [27:0] act_segs;
    for (int i = 0; i < 4; i++)
      exp_segs[7*i +: 7] = ~lit_segments(exp_div[4*i +: 4]);   // Active low
    act_segs = {d3, d2, d1, d0};
    if (exp_segs !== act_segs)
    begin
      $display("Error: test %s digits for divider %0d expected %h actual %h",
               name, exp_div, exp_segs, act_segs);
      end_with_failure();
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      $display("Error: test %s led expected %b actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  // ==================================================
  // Flash port and audio sink
  // ==================================================
  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      flash_waitrequest   <= 1'b0;
      flash_readdatavalid <= 1'b0;
      audio_ready         <= 1'b0;
      rdv_cnt             <= 0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      flash_waitrequest   <= (rand_bits(1) != 0);
      if (flash_read && !flash_waitrequest)
      begin
        rd_addr <= flash_address;          // Read accepted
        rdv_cnt <= 1 + rand_bits(2);
      end
      else if (rdv_cnt != 0)
      begin
        rdv_cnt <= rdv_cnt - 1;
        if (rdv_cnt == 1)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= flash_word(rd_addr);
        end
      end
      audio_ready <= ready_random ? (rand_bits(1) != 0) : 1'b1;
    end
  end

  // Every accepted sample is checked here
  always @(posedge CLK_50M)
  begin
    if (!reset)
    begin
      if (led_wait == 1)
        check_led(cur_name, exp_led, led);
      if (led_wait != 0)
        led_wait = led_wait - 1;
      if (audio_valid && audio_ready)
      begin
        check_sample(cur_name, expected_sample(taken), audio_sample);
        mag_sum = mag_sum + magnitude(expected_sample(taken));
        taken   = taken + 1;
        if (taken % `METER_LEN == 0)
        begin
          exp_led  = thermometer((mag_sum / 16) / 16);   // Average, then bar level
          mag_sum  = 0;
          led_wait = 2;
        end
      end
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic add_row(input string name, input int key_action, input int events,
                         input bit random_ready, input int samples, input clk_div_t div);
    row_name[row_count]    = name;
    row_key[row_count]     = key_action;
    row_events[row_count]  = events;
    row_random[row_count]  = random_ready;
    row_samples[row_count] = samples;
    row_div[row_count]     = div;
    row_count = row_count + 1;
  endtask

  // Hold a key long enough for exactly the given number of events
  task automatic press_key(input int key_action, input int events);
    int bit_idx;
    int hold;
    bit_idx = (key_action == KEY_UP) ? 0 : (key_action == KEY_DOWN) ? 1 : 2;
    hold    = REPEAT_INTERVAL * (events - 1) + REPEAT_INTERVAL / 2;
    @(posedge CLK_50M);
    key[bit_idx] <= 1'b0;
    repeat (hold) @(posedge CLK_50M);
    key[bit_idx] <= 1'b1;
    repeat (8) @(posedge CLK_50M);
  endtask

  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge CLK_50M);
    $display("Timeout: the DUT did not deliver all samples within %0d cycles", limit_cycles);
    end_with_failure();
  end

  initial
  begin
    int target;
    int limit;
    reset               = 1'b1;
    key                 = 3'b111;   // Keys released
    flash_waitrequest   = 1'b0;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    audio_ready         = 1'b0;

    add_row("stream_start", KEY_NONE, 0,  1'b0, 20, 16'd3472);
    add_row("speed_up_5",   KEY_UP,   5,  1'b1, 16, 16'd2972);
    add_row("slow_down_3",  KEY_DOWN, 3,  1'b1, 12, 16'd3272);
    add_row("up_clamp",     KEY_UP,   40, 1'b0, 40, 16'd200);   // Hits MIN_DIV
    add_row("rate_reset",   KEY_RST,  1,  1'b1, 16, 16'd3472);

    limit = 100;
    for (int r = 0; r < NUM_ROWS; r++)
      limit = limit + row_samples[r] * (`MAX_DIV + 20) + REPEAT_INTERVAL * (row_events[r] + 1);
    limit_cycles = limit;

    repeat (8) @(posedge CLK_50M);
    reset <= 1'b0;
    repeat (3) @(posedge CLK_50M);
    check_div("after_reset", `DEFAULT_DIV, hex0, hex1, hex2, hex3);
    check_led("after_reset", 8'h00, led);

    target = 0;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      cur_name     <= row_name[r];
      ready_random <= row_random[r];
      if (row_key[r] != KEY_NONE)
        press_key(row_key[r], row_events[r]);
      check_div(row_name[r], row_div[r], hex0, hex1, hex2, hex3);
      target = target + row_samples[r];
      wait (taken >= target);
      @(posedge CLK_50M);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: simple_ipod.sv
`timescale 1ns/1ps
`include "simple_ipod_consts.svh"

module simple_ipod import ipod_pkg::*; #(
  parameter int          REPEAT_CYCLES = `REPEAT_CYCLES,
  parameter flash_addr_t LAST_WORD     = `SONG_LAST_WORD
) (
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic [2:0]  key,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output logic        audio_valid,
  output sample_t     audio_sample,
  input  logic        audio_ready,
  output logic [7:0]  led,
  output seg7_t       hex0,
  output seg7_t       hex1,
  output seg7_t       hex2,
  output seg7_t       hex3
);

  logic     speed_up;
  logic     speed_down;
  logic     speed_reset;
  clk_div_t clk_div;
  logic     sample_tick;
  logic     meter_strobe;
  sample_t  meter_sample;

  // ==================================================
  // Input side: keys and playback rate
  // ==================================================
  key_conditioner #(.REPEAT_CYCLES(REPEAT_CYCLES)) key_conditioner_inst (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .key         (key),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset)
  );

  sample_rate_ctrl sample_rate_ctrl_inst (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .clk_div     (clk_div),
    .sample_tick (sample_tick)
  );

  // ==================================================
  // Flash to audio stream
  // ==================================================
  sample_sequencer #(.LAST_WORD(LAST_WORD)) sample_sequencer_inst (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .sample_tick         (sample_tick),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .audio_valid         (audio_valid),
    .audio_sample        (audio_sample),
    .audio_ready         (audio_ready),
    .meter_strobe        (meter_strobe),
    .meter_sample        (meter_sample)
  );

  // ==================================================
  // Output side: LED bar and hex digits
  // ==================================================
  level_meter level_meter_inst (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .meter_strobe (meter_strobe),
    .meter_sample (meter_sample),
    .led          (led)
  );

  hex_display hex_display_inst (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .clk_div (clk_div),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3)
  );

endmodule

// File: hex_display.sv
`timescale 1ns/1ps

module hex_display import ipod_pkg::*; (
  input  logic     CLK_50M,
  input  logic     reset,
  input  clk_div_t clk_div,
  output seg7_t    hex0,
  output seg7_t    hex1,
  output seg7_t    hex2,
  output seg7_t    hex3
);

  // Nibble to active-low segments, bit 0 is segment a
  function automatic seg7_t hex_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_seg = 7'h40;
      4'h1: hex_seg = 7'h79;
      4'h2: hex_seg = 7'h24;
      4'h3: hex_seg = 7'h30;
      4'h4: hex_seg = 7'h19;
      4'h5: hex_seg = 7'h12;
      4'h6: hex_seg = 7'h02;
      4'h7: hex_seg = 7'h78;
      4'h8: hex_seg = 7'h00;
      4'h9: hex_seg = 7'h10;
      4'hA: hex_seg = 7'h08;
      4'hB: hex_seg = 7'h03;   // Lower case b
      4'hC: hex_seg = 7'h46;
      4'hD: hex_seg = 7'h21;   // Lower case d
      4'hE: hex_seg = 7'h06;
      default: hex_seg = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      hex0 <= 7'h7F;   // Blank
      hex1 <= 7'h7F;
      hex2 <= 7'h7F;
      hex3 <= 7'h7F;
    end
    else
    begin
      hex0 <= hex_seg(clk_div[3:0]);
      hex1 <= hex_seg(clk_div[7:4]);
      hex2 <= hex_seg(clk_div[11:8]);
      hex3 <= hex_seg(clk_div[15:12]);
    end
  end

endmodule

// File: level_meter.sv
`timescale 1ns/1ps
`include "simple_ipod_consts.svh"

module level_meter import ipod_pkg::*; (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       meter_strobe,
  input  sample_t    meter_sample,
  output logic [7:0] led
);

  localparam int LEN_LOG2 = $clog2(`METER_LEN);
  localparam int SUM_W    = `SAMPLE_W + LEN_LOG2;

  logic [`SAMPLE_W-1:0] mag;       // 0 to 128
  logic [SUM_W-1:0]     sum;
  logic [SUM_W-1:0]     sum_next;
  logic [LEN_LOG2-1:0]  count;
  logic [`SAMPLE_W-1:0] avg;
  logic [3:0]           level;     // 0 to 8 LEDs

  // -128 wraps to 8'h80, read unsigned as 128
  assign mag      = meter_sample[`SAMPLE_W-1] ? `SAMPLE_W'(-meter_sample) : meter_sample;
  assign sum_next = sum + SUM_W'(mag);
  assign avg      = `SAMPLE_W'(sum_next >> LEN_LOG2);
  assign level    = 4'(avg >> 4);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      sum   <= '0;
      count <= '0;
      led   <= 8'h00;
    end
    else if (meter_strobe)
    begin
      if (count == LEN_LOG2'(`METER_LEN - 1))
      begin
        sum   <= '0;                          // Block done
        count <= '0;
        led   <= 8'((9'd1 << level) - 9'd1);  // Thermometer bar
      end
      else
      begin
        sum   <= sum_next;
        count <= count + 1'b1;
      end
    end
  end

endmodule

// File: sample_sequencer.sv
`timescale 1ns/1ps
`include "simple_ipod_consts.svh"

module sample_sequencer import ipod_pkg::*; #(
  parameter flash_addr_t LAST_WORD = `SONG_LAST_WORD
) (
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic        sample_tick,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  logic        flash_readdatavalid,
  input  flash_word_t flash_readdata,
  output logic        audio_valid,
  output sample_t     audio_sample,
  input  logic        audio_ready,
  output logic        meter_strobe,
  output sample_t     meter_sample
);

  localparam logic [1:0] S_IDLE  = 2'd0;   // Wait for a tick
  localparam logic [1:0] S_FETCH = 2'd1;   // Read request out
  localparam logic [1:0] S_WAIT  = 2'd2;   // Wait for the word
  localparam logic [1:0] S_OUT   = 2'd3;   // Sample offered

  logic [1:0]  state;
  logic [1:0]  byte_idx;
  flash_word_t word_reg;
  logic        next_byte;
  logic        word_arrives;
  logic        sample_taken;

  assign next_byte    = (state == S_IDLE) && sample_tick && (byte_idx != 2'd0);
  assign word_arrives = (state == S_WAIT) && flash_readdatavalid;
  assign sample_taken = (state == S_OUT) && audio_ready;

  // ==================================================
  // Control FSM
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state         <= S_IDLE;
      flash_read    <= 1'b0;
      flash_address <= '0;
      audio_valid   <= 1'b0;
      meter_strobe  <= 1'b0;
      byte_idx      <= 2'd0;
    end
    else
    begin
      meter_strobe <= 1'b0;
      case (state)
        S_IDLE:
          if (sample_tick && byte_idx == 2'd0)
          begin
            flash_read <= 1'b1;             // Word used up, fetch the next
            state      <= S_FETCH;
          end
          else if (next_byte)
          begin
            audio_valid <= 1'b1;
            state       <= S_OUT;
          end
        S_FETCH:
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= S_WAIT;
          end
        S_WAIT:
          if (word_arrives)
          begin
            audio_valid <= 1'b1;
            state       <= S_OUT;
          end
        default:
          if (sample_taken)
          begin
            audio_valid  <= 1'b0;
            meter_strobe <= 1'b1;
            byte_idx     <= byte_idx + 1'b1;
            if (byte_idx == 2'd3)
              flash_address <= (flash_address == LAST_WORD) ? '0 : flash_address + 1'b1;
            state <= S_IDLE;
          end
      endcase
    end
  end

  // Word and sample holding registers
  always_ff @(posedge CLK_50M)
  begin
    if (word_arrives)
    begin
      word_reg     <= flash_readdata;
      audio_sample <= flash_readdata[`SAMPLE_W-1:0];   // Byte 0 goes straight out
    end
    else if (next_byte)
      audio_sample <= word_reg[{byte_idx, 3'b000} +: `SAMPLE_W];
    if (sample_taken)
      meter_sample <= audio_sample;
  end

  a_audio_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    audio_valid && !audio_ready |=> audio_valid && $stable(audio_sample));

  a_flash_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

endmodule

// File: sample_rate_ctrl.sv
`timescale 1ns/1ps
`include "simple_ipod_consts.svh"

module sample_rate_ctrl import ipod_pkg::*; (
  input  logic     CLK_50M,
  input  logic     reset,
  input  logic     speed_up,
  input  logic     speed_down,
  input  logic     speed_reset,
  output clk_div_t clk_div,
  output logic     sample_tick
);

  clk_div_t div_cnt;

  // Divider register, clamped at both ends
  always_ff @(posedge CLK_50M)
  begin
    if (reset || speed_reset)
      clk_div <= `DIV_W'(`DEFAULT_DIV);
    else if (speed_up)
    begin
      if (clk_div < `DIV_W'(`MIN_DIV + `SPEED_STEP))
        clk_div <= `DIV_W'(`MIN_DIV);
      else
        clk_div <= clk_div - `DIV_W'(`SPEED_STEP);
    end
    else if (speed_down)
    begin
      if (clk_div > `DIV_W'(`MAX_DIV - `SPEED_STEP))
        clk_div <= `DIV_W'(`MAX_DIV);
      else
        clk_div <= clk_div + `DIV_W'(`SPEED_STEP);
    end
  end

  // Tick once per clk_div cycles
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      div_cnt     <= `DIV_W'(`DEFAULT_DIV - 1);
      sample_tick <= 1'b0;
    end
    else if (div_cnt == '0)
    begin
      div_cnt     <= clk_div - 1'b1;   // Picks up a new rate at the wrap
      sample_tick <= 1'b1;
    end
    else
    begin
      div_cnt     <= div_cnt - 1'b1;
      sample_tick <= 1'b0;
    end
  end

  a_div_range: assert property (@(posedge CLK_50M) disable iff (reset)
    clk_div >= `DIV_W'(`MIN_DIV) && clk_div <= `DIV_W'(`MAX_DIV));

endmodule

// File: key_conditioner.sv
`timescale 1ns/1ps
`include "simple_ipod_consts.svh"

module key_conditioner #(
  parameter int REPEAT_CYCLES = `REPEAT_CYCLES
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [2:0] key,         // Active low push keys
  output logic       speed_up,
  output logic       speed_down,
  output logic       speed_reset
);

  localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);

  logic [2:0] key_meta;    // First sync stage, already inverted
  logic [2:0] key_sync;
  logic [2:0] key_prev;    // For press edge
  logic [2:0] key_event;
  logic [CNT_W-1:0] rep_cnt [3];

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta  <= '0;
      key_sync  <= '0;
      key_prev  <= '0;
      key_event <= '0;
      for (int i = 0; i < 3; i++)
      begin
        rep_cnt[i] <= '0;
      end
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
      key_prev <= key_sync;
      for (int i = 0; i < 3; i++)
      begin
        key_event[i] <= 1'b0;
        if (!key_sync[i])
          rep_cnt[i] <= '0;                 // Released, no repeat
        else if (!key_prev[i] || rep_cnt[i] == CNT_W'(REPEAT_CYCLES - 1))
        begin
          key_event[i] <= 1'b1;             // Press edge or repeat
          rep_cnt[i]   <= '0;
        end
        else
          rep_cnt[i] <= rep_cnt[i] + 1'b1;
      end
    end
  end

  assign speed_up    = key_event[0];
  assign speed_down  = key_event[1];
  assign speed_reset = key_event[2];

endmodule

// File: ipod_pkg.sv
`include "simple_ipod_consts.svh"

package ipod_pkg;

  // One signed audio sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // Flash data word, four samples, lowest byte first
  typedef logic [`WORD_W-1:0] flash_word_t;

  // Flash word address
  typedef logic [`ADDR_W-1:0] flash_addr_t;

  // Playback rate divider
  typedef logic [`DIV_W-1:0] clk_div_t;

  // Seven-segment pattern, active low, segment a in bit 0
  typedef logic [6:0] seg7_t;

endpackage

// File: simple_ipod_consts.svh
`ifndef SIMPLE_IPOD_CONSTS_SVH
`define SIMPLE_IPOD_CONSTS_SVH

// Data path widths
`define SAMPLE_W 8
`define WORD_W 32
`define ADDR_W 23
`define DIV_W 16

// Playback rate divider, in CLK_50M cycles per sample
`define DEFAULT_DIV 3472
`define SPEED_STEP 100
`define MIN_DIV 200
`define MAX_DIV 65000

// Last word address of the song before wrapping to zero
`define SONG_LAST_WORD 23'h7FFFF

// Samples per LED bar update
`define METER_LEN 16

// Key repeat interval, ten events per second
`define REPEAT_CYCLES 5000000

`endif
